// ==== sources.f ====
logic/pdp8_pkg.sv
logic/pdp8_mem_if.sv
logic/pdp8_memory.sv
logic/pdp8_operate.sv
logic/pdp8_control.sv
logic/pdp8_top.sv
verification/pdp8_checker.sv
verification/pdp8_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the PDP-8 testbench with Verilator, run it, then look for the pass line
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module pdp8_tb \
	-f sources.f > build.log 2>&1 &&
	./obj_dir/Vpdp8_tb > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log 2>/dev/null &&
	{ echo "PASS"; exit 0; } ||
	{ echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== verification/pdp8_tb.sv ====
`timescale 1ns/1ps
/* PDP-8 core testbench
   Case table, program loader, run and halt wait, result checks, watchdog */
module pdp8_tb import pdp8_pkg::*;;

	localparam int    CLK_PERIOD  = 10;
	localparam int    NUM_CASES   = 7;
	localparam int    PROG_LEN    = 12;
	localparam int    DATA_LEN    = 4;
	localparam addr_t START_PC    = 12'o0200;
	localparam int    LOAD_CYCLES = PROG_LEN + DATA_LEN + 8;   // Load, start, readback
	localparam int    TIMEOUT_CYCLES = NUM_CASES * (400 + LOAD_CYCLES) + 16;

	logic  clk;
	logic  rst_n;
	logic  i_start;
	logic  i_load_we;
	addr_t i_load_addr;
	word_t i_load_data;
	word_t i_sr;
	word_t o_load_rdata;
	word_t o_ac;
	logic  o_link;
	addr_t o_pc;
	logic  o_running;
	logic  o_halted;

	// ==================================================
	// Case table
	// ==================================================
	string case_name [NUM_CASES];
	word_t prog      [NUM_CASES][PROG_LEN];          // Words from 0o200 on
	addr_t data_addr [NUM_CASES][DATA_LEN];
	word_t data_val  [NUM_CASES][DATA_LEN];
	int    data_len  [NUM_CASES];
	word_t sr_val    [NUM_CASES];
	word_t exp_ac    [NUM_CASES];
	logic  exp_link  [NUM_CASES];
	addr_t chk_addr  [NUM_CASES];
	word_t exp_mem   [NUM_CASES];
	addr_t exp_pc    [NUM_CASES];                    // HLT address plus one

	int    n_checks;
	int    n_errors;
	int    cur_case;
	logic  waiting_halt;
	logic  finished;
	word_t rd;

	pdp8_top #(
		.START_PC (START_PC)
	) i_dut (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_start      (i_start),
		.i_load_we    (i_load_we),
		.i_load_addr  (i_load_addr),
		.i_load_data  (i_load_data),
		.i_sr         (i_sr),
		.o_load_rdata (o_load_rdata),
		.o_ac         (o_ac),
		.o_link       (o_link),
		.o_pc         (o_pc),
		.o_running    (o_running),
		.o_halted     (o_halted)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic set_row(input int idx, input string name, input word_t sr, input word_t ac,
		input logic link, input addr_t chk, input word_t mem_exp, input int ndata,
		input addr_t pc);
		case_name[idx] = name;
		sr_val[idx]    = sr;
		exp_ac[idx]    = ac;
		exp_link[idx]  = link;
		chk_addr[idx]  = chk;
		exp_mem[idx]   = mem_exp;
		data_len[idx]  = ndata;
		exp_pc[idx]    = pc;
	endtask

	task automatic fill_table();
		word_t acc;
		logic  lnk;
		// 6543 + 3210 as 13-bit sum into link:AC, then mask with 0707
		{lnk, acc} = {1'b0, 12'o6543} + {1'b0, 12'o3210};
		acc = acc & 12'o0707;
		set_row(0, "tad_and", 12'o0000, acc, lnk, 12'o0052, 12'o0707, 3,
			12'o0204);
		prog[0] = '{12'o1050, 12'o1051, 12'o0052, 12'o7402, 12'o7402, 12'o7402,
			12'o7402, 12'o7402, 12'o7402, 12'o7402, 12'o7402, 12'o7402};
		data_addr[0] = '{12'o0050, 12'o0051, 12'o0052, 12'o0000};
		data_val[0]  = '{12'o6543, 12'o3210, 12'o0707, 12'o0000};

		// DCA clears AC, ISZ of 7777 wraps to 0 and skips the CMA
		set_row(1, "dca_isz", 12'o0000, 12'o1234, 1'b0, 12'o0062, 12'o0000, 3,
			12'o0206);
		prog[1] = '{12'o1060, 12'o3061, 12'o2062, 12'o7040, 12'o1061, 12'o7402,
			12'o7402, 12'o7402, 12'o7402, 12'o7402, 12'o7402, 12'o7402};
		data_addr[1] = '{12'o0060, 12'o0061, 12'o0062, 12'o0000};
		data_val[1]  = '{12'o1234, 12'o5555, 12'o7777, 12'o0000};

		// Pointer 0o10 goes 0077 -> 0100 first, operand 0025 + 0042 via 0o220
		// IOT 6410 with the indirect bit is a no-op and leaves 0o10 alone
		set_row(2, "autoindex", 12'o0000, 12'o0067, 1'b0, 12'o0010, 12'o0100, 4,
			12'o0204);
		prog[2] = '{12'o1410, 12'o1620, 12'o6410, 12'o7402, 12'o7402, 12'o7402,
			12'o7402, 12'o7402, 12'o7402, 12'o7402, 12'o7402, 12'o7402};
		data_addr[2] = '{12'o0010, 12'o0100, 12'o0220, 12'o0300};
		data_val[2]  = '{12'o0077, 12'o0025, 12'o0300, 12'o0042};

		// Same program, current-page pointer must stay put
		set_row(3, "indirect_page", 12'o0000, 12'o0067, 1'b0, 12'o0220, 12'o0300, 4,
			12'o0204);
		prog[3]      = prog[2];
		data_addr[3] = data_addr[2];
		data_val[3]  = data_val[2];

		// JMS 0210 saves 0201, body adds 5, JMP I back, IAC makes 6
		set_row(4, "jms_jmp", 12'o0000, 12'o0006, 1'b0, 12'o0210, 12'o0201, 1,
			12'o0203);
		prog[4] = '{12'o4210, 12'o7001, 12'o7402, 12'o7402, 12'o7402, 12'o7402,
			12'o7402, 12'o7402, 12'o0000, 12'o1071, 12'o5610, 12'o7402};
		data_addr[4] = '{12'o0071, 12'o0000, 12'o0000, 12'o0000};
		data_val[4]  = '{12'o0005, 12'o0000, 12'o0000, 12'o0000};

		// CLA CLL CMA IAC RTL: 0 -> 7777 -> 0 with L=1 -> 0002 L=0, then OR 5270
		set_row(5, "group1_osr", 12'o5270, 12'o5272, 1'b0, 12'o0200, 12'o7347, 0,
			12'o0203);
		prog[5] = '{12'o7347, 12'o7404, 12'o7402, 12'o7402, 12'o7402, 12'o7402,
			12'o7402, 12'o7402, 12'o7402, 12'o7402, 12'o7402, 12'o7402};
		data_addr[5] = '{12'o0000, 12'o0000, 12'o0000, 12'o0000};
		data_val[5]  = '{12'o0000, 12'o0000, 12'o0000, 12'o0000};

		// SZA skips, SNL falls through (+2), SPA skips, CML then SNA SZL falls through (+10)
		set_row(6, "group2_skips", 12'o0000, 12'o0012, 1'b1, 12'o0074, 12'o0001, 4,
			12'o0212);
		prog[6] = '{12'o7440, 12'o1074, 12'o7420, 12'o1075, 12'o7510, 12'o1076,
			12'o7020, 12'o7470, 12'o1077, 12'o7402, 12'o7402, 12'o7402};
		data_addr[6] = '{12'o0074, 12'o0075, 12'o0076, 12'o0077};
		data_val[6]  = '{12'o0001, 12'o0002, 12'o0004, 12'o0010};
	endtask

	// ==================================================
	// Load port access
	// ==================================================
	task automatic load_word(input addr_t a, input word_t d);
		@(posedge clk);
		i_load_we   <= 1'b1;
		i_load_addr <= a;
		i_load_data <= d;
	endtask

	task automatic read_word(input addr_t a, output word_t d);
		@(posedge clk);
		i_load_we   <= 1'b0;
		i_load_addr <= a;
		@(posedge clk);                              // Word registered here
		@(negedge clk);
		d = o_load_rdata;
	endtask

	task automatic run_case(input int c);
		cur_case = c;
		for (int i = 0; i < PROG_LEN; i++)
			load_word(START_PC + addr_t'(i), prog[c][i]);
		for (int i = 0; i < data_len[c]; i++)
			load_word(data_addr[c][i], data_val[c][i]);
		@(posedge clk);
		i_load_we <= 1'b0;
		i_sr      <= sr_val[c];
		@(posedge clk);
		i_start <= 1'b1;                             // One-cycle run strobe
		@(posedge clk);
		i_start <= 1'b0;
		waiting_halt = 1'b1;
		@(negedge clk);
		n_checks++;
		if (o_running !== 1'b1) begin
			n_errors++;
			$display("Mismatch %s running after start: expected 1, actual %0d",
				case_name[c], o_running);
		end
		while (!o_halted)
			@(negedge clk);
		waiting_halt = 1'b0;

		n_checks++;
		if (o_running !== 1'b0) begin
			n_errors++;
			$display("Mismatch %s running at halt: expected 0, actual %0d",
				case_name[c], o_running);
		end
		n_checks++;
		if (o_pc !== exp_pc[c]) begin
			n_errors++;
			$display("Mismatch %s PC: expected %o, actual %o", case_name[c], exp_pc[c], o_pc);
		end
		n_checks++;
		if (o_ac !== exp_ac[c]) begin
			n_errors++;
			$display("Mismatch %s AC: expected %o, actual %o", case_name[c], exp_ac[c], o_ac);
		end
		n_checks++;
		if (o_link !== exp_link[c]) begin
			n_errors++;
			$display("Mismatch %s link: expected %0d, actual %0d", case_name[c],
				exp_link[c], o_link);
		end
		read_word(chk_addr[c], rd);
		n_checks++;
		if (rd !== exp_mem[c]) begin
			n_errors++;
			$display("Mismatch %s mem[%o]: expected %o, actual %o", case_name[c],
				chk_addr[c], exp_mem[c], rd);
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		rst_n        = 1'b0;
		i_start      = 1'b0;
		i_load_we    = 1'b0;
		i_load_addr  = '0;
		i_load_data  = '0;
		i_sr         = '0;
		n_checks     = 0;
		n_errors     = 0;
		cur_case     = 0;
		waiting_halt = 1'b0;
		finished     = 1'b0;
		fill_table();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int c = 0; c < NUM_CASES; c++)
			run_case(c);
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		finished = 1'b1;
		if (n_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog, budget scales with the case count
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		n_errors++;
		if (waiting_halt)
			$display("Timeout: case %s never halted", case_name[cur_case]);
		else
			$display("Timeout: run did not finish in time during case %s",
				case_name[cur_case]);
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		finished = 1'b1;
		$display("Simulation failed");
		$finish;
	end

	// Run stopped early, e.g. by a failed assertion
	final begin
		if (!finished)
			$display("Simulation failed");
	end

endmodule

// ==== verification/pdp8_checker.sv ====
`timescale 1ns/1ps
/* Run and halt control assertions for the PDP-8 control FSM */
module pdp8_checker import pdp8_pkg::*; (
	input logic  i_clk,
	input logic  i_rst_n,
	input logic  i_start,
	input logic  i_running,
	input logic  i_halted,
	input word_t i_ac
);

	// Never running and halted together and a run ends only in halt
	a_run_halt_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_running && i_halted) && (!$fell(i_running) || i_halted))
		else $error("running and halted both high, or run stopped without halt");

	// Start strobe while stopped begins the run one cycle later
	a_start_runs: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_start && !i_running) |=> i_running)
		else $error("start while stopped did not raise running");

	// Halted core keeps its AC until restarted
	a_halt_ac_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_halted && !i_start) |=> $stable(i_ac))
		else $error("AC changed while halted");

endmodule

bind pdp8_control pdp8_checker i_checker (
	.i_clk     (i_clk),
	.i_rst_n   (i_rst_n),
	.i_start   (i_start),
	.i_running (o_running),
	.i_halted  (o_halted),
	.i_ac      (o_ac)
);

// ==== logic/pdp8_top.sv ====
`timescale 1ns/1ps
/* PDP-8 core top level
   Memory, control FSM and operate unit on one memory bus */
module pdp8_top import pdp8_pkg::*; #(
	parameter addr_t START_PC = 12'o0200
) (
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  logic  i_start,
	input  logic  i_load_we,
	input  addr_t i_load_addr,
	input  word_t i_load_data,
	input  word_t i_sr,
	output word_t o_load_rdata,
	output word_t o_ac,
	output logic  o_link,
	output addr_t o_pc,
	output logic  o_running,
	output logic  o_halted
);

	pdp8_mem_if i_mem_bus ();

	// Operate unit results back to control
	word_t instr;
	word_t opr_ac;
	logic  opr_link;
	logic  opr_skip;
	logic  opr_halt;

	pdp8_memory i_memory (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_load_we    (i_load_we),
		.i_load_addr  (i_load_addr),
		.i_load_data  (i_load_data),
		.o_load_rdata (o_load_rdata),
		.mem          (i_mem_bus)
	);

	pdp8_control #(
		.START_PC (START_PC)
	) i_control (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.o_instr    (instr),
		.o_ac       (o_ac),
		.o_link     (o_link),
		.i_opr_ac   (opr_ac),
		.i_opr_link (opr_link),
		.i_opr_skip (opr_skip),
		.i_opr_halt (opr_halt),
		.o_pc       (o_pc),
		.o_running  (o_running),
		.o_halted   (o_halted),
		.mem        (i_mem_bus)
	);

	pdp8_operate i_operate (
		.i_instr (instr),
		.i_ac    (o_ac),                         // Live AC from control
		.i_link  (o_link),
		.i_sr    (i_sr),
		.o_ac    (opr_ac),
		.o_link  (opr_link),
		.o_skip  (opr_skip),
		.o_halt  (opr_halt)
	);

endmodule

// ==== logic/pdp8_control.sv ====
`timescale 1ns/1ps
/* PDP-8 instruction FSM
   PC, IR, AC, link, effective address with defer and auto-index */
module pdp8_control import pdp8_pkg::*; #(
	parameter addr_t START_PC = 12'o0200
) (
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  logic  i_start,                       // Run strobe
	output word_t o_instr,                       // To operate unit
	output word_t o_ac,
	output logic  o_link,
	input  word_t i_opr_ac,
	input  logic  i_opr_link,
	input  logic  i_opr_skip,
	input  logic  i_opr_halt,
	output addr_t o_pc,
	output logic  o_running,
	output logic  o_halted,
	pdp8_mem_if.core mem
);

	state_e state_q;
	addr_t  pc_q;
	word_t  ir_q;
	word_t  ac_q;
	logic   link_q;
	addr_t  ea_q;                                // Pointer, then operand address
	word_t  md_q;                                // ISZ result
	logic   autoidx_q;

	word_t       instr;
	opcode_e     op;
	addr_t       instr_pc;
	page_t       cur_page;
	offset_t     offset;
	addr_t       ea_direct;
	logic        autoidx_now;
	logic        dispatch;                       // Operand address known this cycle
	addr_t       ea_now;
	word_t       ptr_inc;
	logic [0:12] sum_tad;

	// ==================================================
	// Decode and address calculation
	// ==================================================
	assign instr    = (state_q == S_DECODE) ? mem.rdata : ir_q;  // Word arrives in DECODE
	assign op       = opcode_e'(instr[0:2]);
	assign instr_pc = pc_q - 12'd1;              // PC already advanced
	assign cur_page = instr_pc[0:4];
	assign offset   = instr[5:11];
	assign ea_direct = instr[BIT_PAGE] ? {cur_page, offset} : {page_t'(0), offset};
	assign autoidx_now = instr[BIT_IND] && !instr[BIT_PAGE]
		&& (ea_direct >= AUTOINDEX_LO) && (ea_direct <= AUTOINDEX_HI);
	assign ptr_inc  = mem.rdata + 12'd1;
	assign sum_tad  = {link_q, ac_q} + {1'b0, mem.rdata};

	always_comb begin
		dispatch = 1'b0;
		ea_now   = ea_direct;
		case (state_q)
			S_DECODE:
				dispatch = (op != OP_IOT) && (op != OP_OPR) && !instr[BIT_IND];
			S_DEFER: begin
				dispatch = !autoidx_q;
				ea_now   = mem.rdata;            // Pointer contents
			end
			S_INDEX_WR: begin
				dispatch = 1'b1;
				ea_now   = ea_q;                 // Incremented pointer
			end
			default: ea_now = ea_q;
		endcase
	end

	// Memory port per state
	always_comb begin
		mem.addr  = ea_now;
		mem.we    = 1'b0;
		mem.wdata = ac_q;
		case (state_q)
			S_FETCH: mem.addr = pc_q;
			S_DEFER: begin
				if (autoidx_q) begin             // Write back pointer + 1
					mem.addr  = ea_q;
					mem.we    = 1'b1;
					mem.wdata = ptr_inc;
				end
			end
			S_EXEC_WR: begin
				mem.addr = ea_q;
				mem.we   = 1'b1;
				case (op)
					OP_ISZ:  mem.wdata = md_q;
					OP_JMS:  mem.wdata = pc_q;   // Return address
					default: mem.wdata = ac_q;   // DCA
				endcase
			end
			default: ;
		endcase
	end

	// ==================================================
	// State and registers
	// ==================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_q <= S_IDLE;
			pc_q    <= '0;
			ac_q    <= '0;
			link_q  <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE, S_HALT: begin
					if (i_start) begin
						pc_q    <= START_PC;
						ac_q    <= '0;
						link_q  <= 1'b0;
						state_q <= S_FETCH;
					end
				end
				S_FETCH: begin
					pc_q    <= pc_q + 12'd1;
					state_q <= S_DECODE;
				end
				S_DECODE: begin
					ir_q      <= mem.rdata;
					ea_q      <= ea_direct;
					autoidx_q <= autoidx_now;
					if (op == OP_OPR) begin
						ac_q   <= i_opr_ac;
						link_q <= i_opr_link;
						if (i_opr_skip)
							pc_q <= pc_q + 12'd1;
						state_q <= i_opr_halt ? S_HALT : S_FETCH;
					end else if (instr[BIT_IND] && (op != OP_IOT)) begin
						state_q <= S_DEFER;
					end else begin
						state_q <= S_FETCH;      // IOT, direct MRIs go via dispatch
					end
				end
				S_DEFER: begin
					if (autoidx_q) begin
						ea_q    <= ptr_inc;
						state_q <= S_INDEX_WR;
					end
				end
				S_EXEC_RD: begin
					state_q <= S_FETCH;
					case (op)
						OP_AND: ac_q <= ac_q & mem.rdata;
						OP_TAD: {link_q, ac_q} <= sum_tad;
						default: begin           // ISZ
							md_q    <= ptr_inc;
							state_q <= S_EXEC_WR;
						end
					endcase
				end
				S_EXEC_WR: begin
					state_q <= S_FETCH;
					case (op)
						OP_ISZ: if (md_q == '0) pc_q <= pc_q + 12'd1;
						OP_DCA: ac_q <= '0;
						OP_JMS: pc_q <= ea_q + 12'd1;
						default: ;
					endcase
				end
				default: ;                       // S_INDEX_WR waits for dispatch
			endcase

			// Operand address ready, branch per opcode
			if (dispatch) begin
				ea_q <= ea_now;
				case (op)
					OP_JMP: begin
						pc_q    <= ea_now;
						state_q <= S_FETCH;
					end
					OP_DCA, OP_JMS: state_q <= S_EXEC_WR;
					default:        state_q <= S_EXEC_RD;  // Read issued this cycle
				endcase
			end
		end
	end

	assign o_running  = (state_q != S_IDLE) && (state_q != S_HALT);
	assign o_halted   = (state_q == S_HALT);
	assign mem.active = o_running;
	assign o_instr    = instr;
	assign o_ac       = ac_q;
	assign o_link     = link_q;
	assign o_pc       = pc_q;

endmodule

// ==== logic/pdp8_operate.sv ====
`timescale 1ns/1ps
/* Operate microinstruction unit
   Group 1 clear, complement, increment, rotate; group 2 skips, OSR, HLT */
module pdp8_operate import pdp8_pkg::*; (
	input  word_t i_instr,
	input  word_t i_ac,
	input  logic  i_link,
	input  word_t i_sr,                          // Front panel switches
	output word_t o_ac,
	output logic  o_link,
	output logic  o_skip,
	output logic  o_halt
);

	word_t       ac;
	logic        link;
	logic [0:12] inc;                            // Carry in bit 0
	logic        cond;                           // OR of SMA, SZA, SNL

	always_comb begin
		ac     = i_ac;
		link   = i_link;
		inc    = '0;
		cond   = 1'b0;
		o_skip = 1'b0;
		o_halt = 1'b0;

		// ==================================================
		// Group 1, fixed sequence
		// ==================================================
		if (!i_instr[OPR_GRP_BIT]) begin
			if (i_instr[G1_CLA])
				ac = '0;                         // Step 1
			if (i_instr[G1_CLL])
				link = 1'b0;
			if (i_instr[G1_CMA])
				ac = ~ac;                        // Step 2
			if (i_instr[G1_CML])
				link = ~link;
			if (i_instr[G1_IAC]) begin           // Step 3
				inc  = {1'b0, ac} + 13'd1;
				ac   = inc[1:12];
				link = link ^ inc[0];            // Carry flips the link
			end
			// Step 4, rotate 13-bit link:AC once or twice
			for (int n = 0; n < 2; n++) begin
				if (n == 0 || i_instr[G1_TWICE]) begin
					if (i_instr[G1_RAR])
						{ac, link} = {link, ac};
					else if (i_instr[G1_RAL])
						{link, ac} = {ac, link};
				end
			end
		end

		// ==================================================
		// Group 2
		// ==================================================
		else if (!i_instr[OPR_G3_BIT]) begin
			// Conditions sampled before CLA
			cond = (i_instr[G2_SMA] && ac[0])
				|| (i_instr[G2_SZA] && (ac == '0))
				|| (i_instr[G2_SNL] && link);
			// AND subgroup skips when none of the direct tests hold
			// No bits selected there means SKP
			o_skip = cond ^ i_instr[G2_REV];
			if (i_instr[G2_CLA])
				ac = '0;
			if (i_instr[G2_OSR])
				ac = ac | i_sr;
			o_halt = i_instr[G2_HLT];
		end

		// Group 3 without MQ leaves AC and link as they are
	end

	assign o_ac   = ac;
	assign o_link = link;

endmodule

// ==== logic/pdp8_memory.sv ====
`timescale 1ns/1ps
/* 4K x 12 synchronous main memory
   Shared between the load port and the running core */
module pdp8_memory import pdp8_pkg::*; (
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  logic  i_load_we,
	input  addr_t i_load_addr,
	input  word_t i_load_data,
	output word_t o_load_rdata,
	pdp8_mem_if.mem mem
);

	word_t mem_array [0:MEM_DEPTH-1];

	addr_t sel_addr;
	word_t sel_wdata;
	logic  sel_we;
	word_t rd_word;                              // Registered read word
	logic  rd_core;                              // Last read was for the core

	// Owner mux, load port only while core is stopped
	always_comb begin
		sel_addr  = mem.active ? mem.addr  : i_load_addr;
		sel_wdata = mem.active ? mem.wdata : i_load_data;
		sel_we    = mem.active ? mem.we    : i_load_we;
	end

	// One access per cycle, old data on read of a written word
	always_ff @(posedge i_clk) begin
		if (sel_we)
			mem_array[sel_addr] <= sel_wdata;
		rd_word <= mem_array[sel_addr];
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			rd_core <= 1'b0;
		else
			rd_core <= mem.active;
	end

	assign mem.rdata    = rd_word;
	assign o_load_rdata = rd_core ? '0 : rd_word;  // Core traffic hidden from load port

endmodule

// ==== logic/pdp8_mem_if.sv ====
`timescale 1ns/1ps
/* Memory bus between control FSM and main memory */
interface pdp8_mem_if import pdp8_pkg::*; ();

	addr_t addr;                                 // Read or write address
	word_t wdata;
	logic  we;                                   // Write at this edge
	word_t rdata;                                // Word from previous cycle's address
	logic  active;                               // Core owns the memory

	// Control side
	modport core (
		output addr, wdata, we, active,
		input  rdata
	);

	// Memory side
	modport mem (
		input  addr, wdata, we, active,
		output rdata
	);

endinterface

// ==== logic/pdp8_pkg.sv ====
/* Shared PDP-8 definitions
   Word types, opcodes, operate microinstruction bits and control states */
package pdp8_pkg;

	// ==================================================
	// Machine words, bit 0 is the MSB as on the PDP-8
	// ==================================================
	localparam int WORD_W    = 12;
	localparam int MEM_DEPTH = 4096;             // Full 12-bit address space

	typedef logic [0:WORD_W-1] word_t;           // AC, MB, IR
	typedef logic [0:WORD_W-1] addr_t;
	typedef logic [0:4]        page_t;           // Address bits 0..4
	typedef logic [0:6]        offset_t;         // Address bits 5..11

	typedef enum logic [2:0] {
		OP_AND, OP_TAD, OP_ISZ, OP_DCA,
		OP_JMS, OP_JMP, OP_IOT, OP_OPR
	} opcode_e;

	// Memory reference bits
	localparam int BIT_IND  = 3;                 // Indirect
	localparam int BIT_PAGE = 4;                 // Current page, else page zero

	// ==================================================
	// Operate microinstruction bits
	// ==================================================
	localparam int OPR_GRP_BIT = 3;              // 0 selects group 1
	localparam int OPR_G3_BIT  = 11;             // Group 3 when set with bit 3

	localparam int G1_CLA   = 4;
	localparam int G1_CLL   = 5;
	localparam int G1_CMA   = 6;
	localparam int G1_CML   = 7;
	localparam int G1_RAR   = 8;
	localparam int G1_RAL   = 9;
	localparam int G1_TWICE = 10;                // RTR / RTL
	localparam int G1_IAC   = 11;

	localparam int G2_CLA = 4;
	localparam int G2_SMA = 5;                   // SPA with REV
	localparam int G2_SZA = 6;                   // SNA with REV
	localparam int G2_SNL = 7;                   // SZL with REV
	localparam int G2_REV = 8;                   // AND subgroup
	localparam int G2_OSR = 9;
	localparam int G2_HLT = 10;

	// Auto-index words on page zero
	localparam addr_t AUTOINDEX_LO = 12'o0010;
	localparam addr_t AUTOINDEX_HI = 12'o0017;

	typedef enum logic [2:0] {
		S_IDLE, S_FETCH, S_DECODE, S_DEFER,
		S_INDEX_WR, S_EXEC_RD, S_EXEC_WR, S_HALT
	} state_e;

endpackage
